//--- source/tcm_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// Private memory bus definitions
// Memory map, bus widths and routing targets shared by the bus blocks
//////////////////////////////////////////////////////////////////////

package tcm_bus_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;   // One enable per byte lane

  //////////////////////////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////////////////////////

  // Private window base, both TCMs live above it
  localparam logic [ADDR_W-1:0] INT_BUS_START = 32'h7000_0000;

  localparam logic [ADDR_W-1:0] ITCM_START = INT_BUS_START;
  localparam logic [ADDR_W-1:0] ITCM_SIZE  = 32'h0000_1000;   // 4 KiB

  localparam logic [ADDR_W-1:0] DTCM_START = INT_BUS_START + 32'h0000_2000;
  localparam logic [ADDR_W-1:0] DTCM_SIZE  = 32'h0000_1000;   // 4 KiB

  // Keep only the bits above each TCM size
  localparam logic [ADDR_W-1:0] ITCM_MASK = ~(ITCM_SIZE - 32'd1);
  localparam logic [ADDR_W-1:0] DTCM_MASK = ~(DTCM_SIZE - 32'd1);

  // TCM geometry, word index taken from addr[11:2]
  localparam int TCM_WORDS = 1024;
  localparam int TCM_IDX_W = $clog2(TCM_WORDS);

  // Where a request goes
  typedef enum logic [1:0] {
    TGT_ITCM = 2'd0,
    TGT_DTCM = 2'd1,
    TGT_EXT  = 2'd2   // Outside the private window
  } target_e;

endpackage

//--- source/mem_port_if.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Memory port bundle
// Request and response wires between a router and one target
//////////////////////////////////////////////////////////////////////

interface mem_port_if;
  import tcm_bus_pkg::*;

  // Request side
  logic              req;      // One cycle strobe, no grant
  logic              we;       // High for writes
  logic [BE_W-1:0]   be;       // Byte lanes written
  logic [ADDR_W-1:0] addr;     // Full byte address
  logic [DATA_W-1:0] wdata;

  // Response side
  logic              rvalid;   // Exactly one per request
  logic [DATA_W-1:0] rdata;
  logic              err;      // Only the external bus raises it

  // Router end
  modport host (
    output req, we, be, addr, wdata,
    input  rvalid, rdata, err
  );

  // Memory or bus end
  modport target (
    input  req, we, be, addr, wdata,
    output rvalid, rdata, err
  );

endinterface

//--- source/addr_decoder.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Address decoder
// Base and mask compare that picks the target of one host address
//////////////////////////////////////////////////////////////////////

module addr_decoder #(
  parameter bit HAS_DTCM = 1'b1   // DTCM window reachable from this side
) (
  input  logic [tcm_bus_pkg::ADDR_W-1:0] addr_i,
  output tcm_bus_pkg::target_e           target_o
);
  import tcm_bus_pkg::*;

  logic hit_itcm;   // Address inside the instruction TCM
  logic hit_dtcm;   // Address inside the data TCM

  // Upper bits must equal the base
  assign hit_itcm = ((addr_i & ITCM_MASK) == ITCM_START);

  // Without a DTCM path the window simply falls through to external
  assign hit_dtcm = HAS_DTCM && ((addr_i & DTCM_MASK) == DTCM_START);

  //////////////////////////////////////////////////////////////////////
  // Priority select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (hit_itcm) begin
      target_o = TGT_ITCM;
    end else if (hit_dtcm) begin
      target_o = TGT_DTCM;
    end else begin
      target_o = TGT_EXT;   // Default route
    end
  end

endmodule

//--- source/bus_router.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Bus router
// Sends one host's requests to ITCM, DTCM or the external bus and
// steers the matching response back by a registered target tag
//////////////////////////////////////////////////////////////////////

module bus_router #(
  parameter bit HAS_DTCM = 1'b1   // Instruction side builds with 0
) (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // Host request
  input  logic                          host_req_i,
  input  logic                          host_we_i,
  input  logic [tcm_bus_pkg::BE_W-1:0]   host_be_i,
  input  logic [tcm_bus_pkg::ADDR_W-1:0] host_addr_i,
  input  logic [tcm_bus_pkg::DATA_W-1:0] host_wdata_i,

  // Host response
  output logic                          host_rvalid_o,
  output logic [tcm_bus_pkg::DATA_W-1:0] host_rdata_o,
  output logic                          host_err_o,

  // Targets
  mem_port_if.host                      itcm_o,
  mem_port_if.host                      dtcm_o,
  mem_port_if.host                      ext_o
);
  import tcm_bus_pkg::*;

  target_e req_tgt;   // Decoded target of the current request
  target_e tag_q;     // Target of the last accepted request

  addr_decoder #(
    .HAS_DTCM (HAS_DTCM)
  ) u_addr_decoder (
    .addr_i   (host_addr_i),
    .target_o (req_tgt)
  );

  //////////////////////////////////////////////////////////////////////
  // Request fan-out, no added delay
  //////////////////////////////////////////////////////////////////////

  // Strobe only on the selected target
  assign itcm_o.req = host_req_i && (req_tgt == TGT_ITCM);
  assign dtcm_o.req = host_req_i && (req_tgt == TGT_DTCM);
  assign ext_o.req  = host_req_i && (req_tgt == TGT_EXT);

  // Payload goes everywhere
  assign itcm_o.we    = host_we_i;
  assign itcm_o.be    = host_be_i;
  assign itcm_o.addr  = host_addr_i;
  assign itcm_o.wdata = host_wdata_i;

  assign dtcm_o.we    = host_we_i;
  assign dtcm_o.be    = host_be_i;
  assign dtcm_o.addr  = host_addr_i;
  assign dtcm_o.wdata = host_wdata_i;

  assign ext_o.we     = host_we_i;
  assign ext_o.be     = host_be_i;
  assign ext_o.addr   = host_addr_i;
  assign ext_o.wdata  = host_wdata_i;

  //////////////////////////////////////////////////////////////////////
  // Response steering
  //////////////////////////////////////////////////////////////////////

  // Host waits on external answers, so one tag is enough
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tag_q <= TGT_ITCM;
    end else if (host_req_i) begin
      tag_q <= req_tgt;
    end
  end

  always_comb begin
    case (tag_q)
      TGT_ITCM: begin
        host_rvalid_o = itcm_o.rvalid;
        host_rdata_o  = itcm_o.rdata;
        host_err_o    = itcm_o.err;
      end
      TGT_DTCM: begin
        host_rvalid_o = dtcm_o.rvalid;
        host_rdata_o  = dtcm_o.rdata;
        host_err_o    = dtcm_o.err;
      end
      default: begin   // External, passes straight through
        host_rvalid_o = ext_o.rvalid;
        host_rdata_o  = ext_o.rdata;
        host_err_o    = ext_o.err;
      end
    endcase
  end

endmodule

//--- source/tcm_dual_port.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Dual port TCM
// Byte writable word memory, one cycle read on both ports
//////////////////////////////////////////////////////////////////////

module tcm_dual_port (
  input  logic       clk_i,
  input  logic       rst_i,
  mem_port_if.target a_i,   // Data side, load and store
  mem_port_if.target b_i    // Fetch side or tied off
);
  import tcm_bus_pkg::*;

  logic [DATA_W-1:0]    mem_q [TCM_WORDS];   // Storage, no reset
  logic [TCM_IDX_W-1:0] a_idx;
  logic [TCM_IDX_W-1:0] b_idx;

  // Replace the enabled lanes of a word
  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] merged;
    merged = old_word;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  // Word index from addr[11:2]
  assign a_idx = a_i.addr[TCM_IDX_W+1:2];
  assign b_idx = b_i.addr[TCM_IDX_W+1:2];

  //////////////////////////////////////////////////////////////////////
  // Writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (b_i.req && b_i.we) begin
      mem_q[b_idx] <= merge_bytes(mem_q[b_idx], b_i.wdata, b_i.be);
    end
    // Later update, so port A wins on the same word
    if (a_i.req && a_i.we) begin
      mem_q[a_idx] <= merge_bytes(mem_q[a_idx], a_i.wdata, a_i.be);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reads and response strobes
  //////////////////////////////////////////////////////////////////////

  // Old word comes back, also on writes
  always_ff @(posedge clk_i) begin
    if (a_i.req) begin
      a_i.rdata <= mem_q[a_idx];
    end
    if (b_i.req) begin
      b_i.rdata <= mem_q[b_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_i.rvalid <= 1'b0;
      b_i.rvalid <= 1'b0;
    end else begin
      a_i.rvalid <= a_i.req;   // Answer one cycle later
      b_i.rvalid <= b_i.req;
    end
  end

  // TCM never faults
  assign a_i.err = 1'b0;
  assign b_i.err = 1'b0;

endmodule

//--- source/tcm_subsystem_top.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// TCM subsystem top
// Data and fetch routers, shared ITCM, DTCM and the external bus ports
//////////////////////////////////////////////////////////////////////

module tcm_subsystem_top (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // Data host
  input  logic                          dhost_req_i,
  input  logic                          dhost_we_i,
  input  logic [tcm_bus_pkg::BE_W-1:0]   dhost_be_i,
  input  logic [tcm_bus_pkg::ADDR_W-1:0] dhost_addr_i,
  input  logic [tcm_bus_pkg::DATA_W-1:0] dhost_wdata_i,
  output logic                          dhost_rvalid_o,
  output logic [tcm_bus_pkg::DATA_W-1:0] dhost_rdata_o,
  output logic                          dhost_err_o,

  // Instruction host, read only
  input  logic                          ihost_req_i,
  input  logic [tcm_bus_pkg::ADDR_W-1:0] ihost_addr_i,
  output logic                          ihost_rvalid_o,
  output logic [tcm_bus_pkg::DATA_W-1:0] ihost_rdata_o,
  output logic                          ihost_err_o,

  // External data bus
  output logic                          ext_data_req_o,
  output logic                          ext_data_we_o,
  output logic [tcm_bus_pkg::BE_W-1:0]   ext_data_be_o,
  output logic [tcm_bus_pkg::ADDR_W-1:0] ext_data_addr_o,
  output logic [tcm_bus_pkg::DATA_W-1:0] ext_data_wdata_o,
  input  logic                          ext_data_rvalid_i,
  input  logic [tcm_bus_pkg::DATA_W-1:0] ext_data_rdata_i,
  input  logic                          ext_data_err_i,

  // External instruction bus
  output logic                          ext_instr_req_o,
  output logic [tcm_bus_pkg::ADDR_W-1:0] ext_instr_addr_o,
  input  logic                          ext_instr_rvalid_i,
  input  logic [tcm_bus_pkg::DATA_W-1:0] ext_instr_rdata_i,
  input  logic                          ext_instr_err_i
);

  // Data side links
  mem_port_if d_itcm_bus ();
  mem_port_if d_dtcm_bus ();
  mem_port_if d_ext_bus ();

  // Fetch side links
  mem_port_if i_itcm_bus ();
  mem_port_if i_dtcm_bus ();   // Goes nowhere
  mem_port_if i_ext_bus ();

  mem_port_if dtcm_b_bus ();   // Idle second DTCM port

  //////////////////////////////////////////////////////////////////////
  // Routers
  //////////////////////////////////////////////////////////////////////

  bus_router #(
    .HAS_DTCM (1'b1)
  ) u_data_router (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .host_req_i    (dhost_req_i),
    .host_we_i     (dhost_we_i),
    .host_be_i     (dhost_be_i),
    .host_addr_i   (dhost_addr_i),
    .host_wdata_i  (dhost_wdata_i),
    .host_rvalid_o (dhost_rvalid_o),
    .host_rdata_o  (dhost_rdata_o),
    .host_err_o    (dhost_err_o),
    .itcm_o        (d_itcm_bus),
    .dtcm_o        (d_dtcm_bus),
    .ext_o         (d_ext_bus)
  );

  bus_router #(
    .HAS_DTCM (1'b0)   // DTCM window fetches go external
  ) u_instr_router (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .host_req_i    (ihost_req_i),
    .host_we_i     (1'b0),   // Fetch never writes
    .host_be_i     ('0),
    .host_addr_i   (ihost_addr_i),
    .host_wdata_i  ('0),
    .host_rvalid_o (ihost_rvalid_o),
    .host_rdata_o  (ihost_rdata_o),
    .host_err_o    (ihost_err_o),
    .itcm_o        (i_itcm_bus),
    .dtcm_o        (i_dtcm_bus),
    .ext_o         (i_ext_bus)
  );

  // Silent responder behind the fetch side DTCM link
  assign i_dtcm_bus.rvalid = 1'b0;
  assign i_dtcm_bus.rdata  = '0;
  assign i_dtcm_bus.err    = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // Memories
  //////////////////////////////////////////////////////////////////////

  tcm_dual_port u_itcm (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .a_i   (d_itcm_bus),   // Loader path
    .b_i   (i_itcm_bus)    // Fetch path
  );

  tcm_dual_port u_dtcm (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .a_i   (d_dtcm_bus),
    .b_i   (dtcm_b_bus)
  );

  // Port B of the DTCM stays idle
  assign dtcm_b_bus.req   = 1'b0;
  assign dtcm_b_bus.we    = 1'b0;
  assign dtcm_b_bus.be    = '0;
  assign dtcm_b_bus.addr  = '0;
  assign dtcm_b_bus.wdata = '0;

  //////////////////////////////////////////////////////////////////////
  // External bus mapping
  //////////////////////////////////////////////////////////////////////

  assign ext_data_req_o      = d_ext_bus.req;
  assign ext_data_we_o       = d_ext_bus.we;
  assign ext_data_be_o       = d_ext_bus.be;
  assign ext_data_addr_o     = d_ext_bus.addr;
  assign ext_data_wdata_o    = d_ext_bus.wdata;
  assign d_ext_bus.rvalid    = ext_data_rvalid_i;
  assign d_ext_bus.rdata     = ext_data_rdata_i;
  assign d_ext_bus.err       = ext_data_err_i;

  // Only request and address leave on the fetch side
  assign ext_instr_req_o     = i_ext_bus.req;
  assign ext_instr_addr_o    = i_ext_bus.addr;
  assign i_ext_bus.rvalid    = ext_instr_rvalid_i;
  assign i_ext_bus.rdata     = ext_instr_rdata_i;
  assign i_ext_bus.err       = ext_instr_err_i;

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset
//////////////////////////////////////////////////////////////////////

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);
  localparam int HALF_NS      = 10;   // 20 ns period
  localparam int RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // Synchronous release on a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- bench/tcm_subsystem_tb.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// TCM subsystem testbench
// Directed tests on both hosts with a reference model of each TCM
//////////////////////////////////////////////////////////////////////

module tcm_subsystem_tb;
  import tcm_bus_pkg::*;

  // Tests take about 250 cycles, the limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic        clk_i, rst_i;
  logic        dhost_req_i, dhost_we_i;
  logic [3:0]  dhost_be_i;
  logic [31:0] dhost_addr_i, dhost_wdata_i;
  logic        dhost_rvalid_o, dhost_err_o;
  logic [31:0] dhost_rdata_o;
  logic        ihost_req_i;
  logic [31:0] ihost_addr_i;
  logic        ihost_rvalid_o, ihost_err_o;
  logic [31:0] ihost_rdata_o;
  logic        ext_data_req_o, ext_data_we_o;
  logic [3:0]  ext_data_be_o;
  logic [31:0] ext_data_addr_o, ext_data_wdata_o;
  logic        ext_data_rvalid_i, ext_data_err_i;
  logic [31:0] ext_data_rdata_i;
  logic        ext_instr_req_o;
  logic [31:0] ext_instr_addr_o;
  logic        ext_instr_rvalid_i, ext_instr_err_i;
  logic [31:0] ext_instr_rdata_i;

  integer seed;
  int     err_count;
  int     check_count;
  int     cycle_cnt;

  // Reference model, valid marks words with a known value
  logic [31:0] itcm_ref [1024];
  logic [31:0] dtcm_ref [1024];
  bit          itcm_valid [1024];
  bit          dtcm_valid [1024];
  logic [31:0] itcm_addrs [$];   // Words loaded in the byte test
  logic [31:0] dtcm_addrs [$];
  logic [3:0]  be_pats [$];

  tb_clock_gen u_clock_gen (.clk_o(clk_i), .rst_o(rst_i));

  tcm_subsystem_top dut_i (.*);

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (err_count == errs_at_start) $display("%s: ok", name);
    else $display("%s: %0d errors", name, err_count - errs_at_start);
  endtask

  // Byte lanes with be set take the new data
  function automatic logic [31:0] lane_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // One data host TCM access, answer exactly one cycle later
  task automatic data_tcm_access(input logic we, input logic [3:0] be,
                                 input logic [31:0] addr, input logic [31:0] wdata,
                                 input logic [31:0] exp_rdata, input bit check_rdata);
    @(posedge clk_i);
    dhost_req_i   <= 1'b1;
    dhost_we_i    <= we;
    dhost_be_i    <= be;
    dhost_addr_i  <= addr;
    dhost_wdata_i <= wdata;
    @(negedge clk_i);   // Request cycle
    check_value("ext_data_req_o", 32'(ext_data_req_o), 32'd0);
    check_value("dhost_rvalid_o", 32'(dhost_rvalid_o), 32'd0);
    @(posedge clk_i);
    dhost_req_i <= 1'b0;
    @(negedge clk_i);   // Answer cycle
    check_value("dhost_rvalid_o", 32'(dhost_rvalid_o), 32'd1);
    if (check_rdata) check_value("dhost_rdata_o", dhost_rdata_o, exp_rdata);
    check_value("dhost_err_o", 32'(dhost_err_o), 32'd0);
  endtask

  // Write through the data host, returned word is the old one
  task automatic tcm_write(input bit to_itcm, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be);
    logic [9:0]  idx;
    logic [31:0] old_word;
    bit          known;
    idx      = addr[11:2];
    old_word = to_itcm ? itcm_ref[idx] : dtcm_ref[idx];
    known    = to_itcm ? itcm_valid[idx] : dtcm_valid[idx];
    data_tcm_access(1'b1, be, addr, wdata, old_word, known);
    if (to_itcm) begin
      itcm_ref[idx]   = lane_merge(old_word, wdata, be);
      itcm_valid[idx] = known || (be == 4'hF);
    end else begin
      dtcm_ref[idx]   = lane_merge(old_word, wdata, be);
      dtcm_valid[idx] = known || (be == 4'hF);
    end
  endtask

  task automatic fetch_itcm(input logic [31:0] addr, input logic [31:0] exp_rdata);
    @(posedge clk_i);
    ihost_req_i  <= 1'b1;
    ihost_addr_i <= addr;
    @(negedge clk_i);
    check_value("ext_instr_req_o", 32'(ext_instr_req_o), 32'd0);
    check_value("ihost_rvalid_o", 32'(ihost_rvalid_o), 32'd0);
    @(posedge clk_i);
    ihost_req_i <= 1'b0;
    @(negedge clk_i);
    check_value("ihost_rvalid_o", 32'(ihost_rvalid_o), 32'd1);
    check_value("ihost_rdata_o", ihost_rdata_o, exp_rdata);
    check_value("ihost_err_o", 32'(ihost_err_o), 32'd0);
  endtask

  // External slave answers 1 to 8 cycles after the request
  task automatic ext_data_access(input logic we, input logic [3:0] be,
                                 input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rnd;
    logic [31:0] rdata;
    int          delay;
    rnd   = $random(seed);
    rdata = $random(seed);
    delay = 1 + int'(rnd[2:0]);
    @(posedge clk_i);
    dhost_req_i   <= 1'b1;
    dhost_we_i    <= we;
    dhost_be_i    <= be;
    dhost_addr_i  <= addr;
    dhost_wdata_i <= wdata;
    @(negedge clk_i);   // Fields pass through in the same cycle
    check_value("ext_data_req_o", 32'(ext_data_req_o), 32'd1);
    check_value("ext_data_we_o", 32'(ext_data_we_o), 32'(we));
    check_value("ext_data_be_o", 32'(ext_data_be_o), 32'(be));
    check_value("ext_data_addr_o", ext_data_addr_o, addr);
    check_value("ext_data_wdata_o", ext_data_wdata_o, wdata);
    @(posedge clk_i);
    dhost_req_i <= 1'b0;
    for (int k = 1; k < delay; k++) begin
      @(negedge clk_i);
      check_value("ext_data_req_o", 32'(ext_data_req_o), 32'd0);
      check_value("dhost_rvalid_o", 32'(dhost_rvalid_o), 32'd0);
      @(posedge clk_i);
    end
    ext_data_rvalid_i <= 1'b1;
    ext_data_rdata_i  <= rdata;
    ext_data_err_i    <= rnd[8];
    @(negedge clk_i);
    check_value("dhost_rvalid_o", 32'(dhost_rvalid_o), 32'd1);
    check_value("dhost_rdata_o", dhost_rdata_o, rdata);
    check_value("dhost_err_o", 32'(dhost_err_o), 32'(rnd[8]));
    @(posedge clk_i);
    ext_data_rvalid_i <= 1'b0;
    ext_data_err_i    <= 1'b0;
  endtask

  task automatic ext_fetch(input logic [31:0] addr);
    logic [31:0] rnd;
    logic [31:0] rdata;
    int          delay;
    rnd   = $random(seed);
    rdata = $random(seed);
    delay = 1 + int'(rnd[2:0]);
    @(posedge clk_i);
    ihost_req_i  <= 1'b1;
    ihost_addr_i <= addr;
    @(negedge clk_i);
    check_value("ext_instr_req_o", 32'(ext_instr_req_o), 32'd1);
    check_value("ext_instr_addr_o", ext_instr_addr_o, addr);
    @(posedge clk_i);
    ihost_req_i <= 1'b0;
    for (int k = 1; k < delay; k++) begin
      @(negedge clk_i);
      check_value("ihost_rvalid_o", 32'(ihost_rvalid_o), 32'd0);
      @(posedge clk_i);
    end
    ext_instr_rvalid_i <= 1'b1;
    ext_instr_rdata_i  <= rdata;
    ext_instr_err_i    <= rnd[8];
    @(negedge clk_i);
    check_value("ihost_rvalid_o", 32'(ihost_rvalid_o), 32'd1);
    check_value("ihost_rdata_o", ihost_rdata_o, rdata);
    check_value("ihost_err_o", 32'(ihost_err_o), 32'(rnd[8]));
    @(posedge clk_i);
    ext_instr_rvalid_i <= 1'b0;
    ext_instr_err_i    <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int errs;
    errs = err_count;
    repeat (4) begin   // Idle bus stays quiet
      @(negedge clk_i);
      check_value("dhost_rvalid_o", 32'(dhost_rvalid_o), 32'd0);
      check_value("ihost_rvalid_o", 32'(ihost_rvalid_o), 32'd0);
      check_value("ext_data_req_o", 32'(ext_data_req_o), 32'd0);
      check_value("ext_instr_req_o", 32'(ext_instr_req_o), 32'd0);
    end
    report_test("reset", errs);
  endtask

  task automatic test_dtcm_rw();
    int          errs;
    logic [31:0] addr;
    logic [31:0] data;
    errs = err_count;
    for (int i = 0; i < 8; i++) begin
      data = $random(seed);
      addr = DTCM_START | (data & 32'h0000_0FFC);
      data = $random(seed);
      dtcm_addrs.push_back(addr);
      tcm_write(1'b0, addr, data, 4'hF);
    end
    foreach (dtcm_addrs[i]) begin
      addr = dtcm_addrs[i];
      data_tcm_access(1'b0, 4'hF, addr, 32'h0, dtcm_ref[addr[11:2]], 1'b1);
    end
    report_test("dtcm read/write", errs);
  endtask

  task automatic test_itcm_bytes();
    int          errs;
    logic [31:0] addr;
    logic [31:0] data;
    errs    = err_count;
    be_pats = {4'b0001, 4'b0110, 4'b1000, 4'b1011};
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      addr = ITCM_START | (data & 32'h0000_0FFC);
      itcm_addrs.push_back(addr);
      data = $random(seed);
      tcm_write(1'b1, addr, data, 4'hF);   // Full word first
      foreach (be_pats[p]) begin
        data = $random(seed);
        tcm_write(1'b1, addr, data, be_pats[p]);
      end
    end
    foreach (itcm_addrs[i]) begin
      addr = itcm_addrs[i];
      fetch_itcm(addr, itcm_ref[addr[11:2]]);
    end
    report_test("itcm byte enables", errs);
  endtask

  // Reads every cycle, ITCM and DTCM in turn
  task automatic test_back_to_back();
    int          errs;
    logic [31:0] addr;
    logic [31:0] exp_q [$];
    errs = err_count;
    for (int i = 0; i <= 8; i++) begin
      @(posedge clk_i);
      if (i < 8) begin
        addr = (i % 2 == 0) ? itcm_addrs[i/2] : dtcm_addrs[i/2];
        exp_q.push_back((i % 2 == 0) ? itcm_ref[addr[11:2]] : dtcm_ref[addr[11:2]]);
        dhost_req_i  <= 1'b1;
        dhost_we_i   <= 1'b0;
        dhost_be_i   <= 4'hF;
        dhost_addr_i <= addr;
      end else begin
        dhost_req_i <= 1'b0;
      end
      @(negedge clk_i);
      if (i > 0) begin   // Answer to the previous request
        check_value("dhost_rvalid_o", 32'(dhost_rvalid_o), 32'd1);
        check_value("dhost_rdata_o", dhost_rdata_o, exp_q.pop_front());
        check_value("dhost_err_o", 32'(dhost_err_o), 32'd0);
      end
    end
    report_test("back to back", errs);
  endtask

  task automatic test_ext_data();
    int          errs;
    logic [31:0] rnd;
    logic [31:0] wdata;
    errs = err_count;
    for (int i = 0; i < 6; i++) begin
      rnd   = $random(seed);
      wdata = $random(seed);
      ext_data_access(rnd[0], rnd[7:4], 32'h4000_0000 | (rnd & 32'h0FFF_FFFC), wdata);
    end
    report_test("external data", errs);
  endtask

  task automatic test_instr_decode();
    int          errs;
    logic [31:0] rnd;
    errs = err_count;
    rnd  = $random(seed);
    ext_fetch(DTCM_START | (rnd & 32'h0000_0FFC));   // DTCM window goes out
    ext_fetch(DTCM_START);
    ext_fetch(ITCM_START + ITCM_SIZE);                // Just above ITCM
    ext_fetch(32'h2000_0000 | (rnd & 32'h00FF_FFFC));
    report_test("instruction decode", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed               = 4835;
    err_count          = 0;
    check_count        = 0;
    dhost_req_i        = 1'b0;
    dhost_we_i         = 1'b0;
    dhost_be_i         = 4'h0;
    dhost_addr_i       = 32'h0;
    dhost_wdata_i      = 32'h0;
    ihost_req_i        = 1'b0;
    ihost_addr_i       = 32'h0;
    ext_data_rvalid_i  = 1'b0;
    ext_data_rdata_i   = 32'h0;
    ext_data_err_i     = 1'b0;
    ext_instr_rvalid_i = 1'b0;
    ext_instr_rdata_i  = 32'h0;
    ext_instr_err_i    = 1'b0;
    @(negedge rst_i);
    test_reset();
    test_dtcm_rw();
    test_itcm_bytes();
    test_back_to_back();
    test_ext_data();
    test_instr_decode();
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) $display("TB PASSED");
    else $display("TB FAILED");
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- list.f
source/tcm_bus_pkg.sv
source/mem_port_if.sv
source/addr_decoder.sv
source/bus_router.sv
source/tcm_dual_port.sv
source/tcm_subsystem_top.sv
bench/tb_clock_gen.sv
bench/tcm_subsystem_tb.sv

//--- Makefile
SRCS := $(wildcard source/*.sv bench/*.sv)

.PHONY: run clean

obj_dir/Vtcm_subsystem_tb: list.f $(SRCS)
	verilator --binary -j 0 --top-module tcm_subsystem_tb -f list.f

run: obj_dir/Vtcm_subsystem_tb
	@out=$$(./obj_dir/Vtcm_subsystem_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
